// File: Bender.yml
package:
  name: aos_shell

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/aos_pkg.sv
      - logic/rst_pipe.sv
      - logic/axil_softreg_bridge.sv
      - logic/softreg_route_tree.sv
      - logic/app_regfile.sv
      - logic/aos_shell.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/aos_shell_tb.sv

// File: aos_shell.f
+incdir+include
logic/aos_pkg.sv
logic/rst_pipe.sv
logic/axil_softreg_bridge.sv
logic/softreg_route_tree.sv
logic/app_regfile.sv
logic/aos_shell.sv
verification/aos_shell_tb.sv

// File: include/aos_config.svh
// --------------------
// Shell configuration
// Slot count, SoftReg address split, bus widths and app register map
// --------------------
`ifndef AOS_CONFIG_SVH
`define AOS_CONFIG_SVH

// Application slots
`define AOS_NUM_APPS      4

// Address split, each slot owns 256 bytes
`define AOS_APP_SEL_LSB   8
`define AOS_APP_SEL_W     2
// Registers are 8 bytes apart, index sits just below the slot index
`define AOS_REG_IDX_W     5

// Bus widths
`define AOS_SR_ADDR_W     32
`define AOS_SR_DATA_W     64
`define AOS_AXIL_DATA_W   32

// Reset pipe depth
`define AOS_RST_STAGES    3

// App register map, register indices
`define AOS_REG_SCRATCH0  0
`define AOS_REG_SCRATCH1  1
`define AOS_REG_SCRATCH2  2
`define AOS_REG_SCRATCH3  3
`define AOS_REG_WR_COUNT  6
`define AOS_REG_APP_ID    7

`endif

// File: logic/aos_pkg.sv
// --------------------
// SoftReg types
// Request, response and the two views of a SoftReg address
// --------------------
`default_nettype none

`include "aos_config.svh"

package aos_pkg;

	// --------------------
	// Address views
	// --------------------

	// Decoded address, high bits ignored so slots alias
	typedef struct packed {
		logic [`AOS_SR_ADDR_W-`AOS_APP_SEL_LSB-`AOS_APP_SEL_W-1:0] unused;
		logic [`AOS_APP_SEL_W-1:0]                                  app_sel;
		logic [`AOS_REG_IDX_W-1:0]                                  reg_idx;
		// Byte lane within one 64-bit register
		logic [`AOS_APP_SEL_LSB-`AOS_REG_IDX_W-1:0]                 byte_off;
	} softreg_addr_fields_t;

	// Raw word or decoded fields
	typedef union packed {
		logic [`AOS_SR_ADDR_W-1:0] raw;
		softreg_addr_fields_t      fields;
	} softreg_addr_u;

	// --------------------
	// SoftReg beats
	// --------------------

	// Request, 98 bits
	typedef struct packed {
		logic                      valid;
		logic                      is_read;
		softreg_addr_u             addr;
		logic [`AOS_SR_DATA_W-1:0] data;
	} softreg_req_t;

	// Response, 65 bits
	typedef struct packed {
		logic                      valid;
		logic [`AOS_SR_DATA_W-1:0] data;
	} softreg_resp_t;

endpackage

`default_nettype wire

// File: logic/aos_shell.sv
// --------------------
// Control register shell
// Host AXI-Lite into a SoftReg tree of per-slot register apps
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aos_config.svh"

module aos_shell (
	input  wire logic                           clk_main_a0,
	input  wire logic                           rst_n,
	// Host AXI-Lite slave
	input  wire logic                           awvalid,
	input  wire logic [`AOS_SR_ADDR_W-1:0]      awaddr,
	output logic                                awready,
	input  wire logic                           wvalid,
	input  wire logic [`AOS_AXIL_DATA_W-1:0]    wdata,
	input  wire logic [`AOS_AXIL_DATA_W/8-1:0]  wstrb,
	output logic                                wready,
	output logic                                bvalid,
	output logic [1:0]                          bresp,
	input  wire logic                           bready,
	input  wire logic                           arvalid,
	input  wire logic [`AOS_SR_ADDR_W-1:0]      araddr,
	output logic                                arready,
	output logic                                rvalid,
	output logic [`AOS_AXIL_DATA_W-1:0]         rdata,
	output logic [1:0]                          rresp,
	input  wire logic                           rready
);

logic                   shell_rst_n;
aos_pkg::softreg_req_t  host_req;
aos_pkg::softreg_resp_t host_resp;
aos_pkg::softreg_req_t  app_req  [`AOS_NUM_APPS];
aos_pkg::softreg_resp_t app_resp [`AOS_NUM_APPS];

// --------------------
// Shell side
// --------------------

// Bridge and tree share one release point
rst_pipe shell_rst_inst (
	.clk_main_a0 (clk_main_a0),
	.rst_n       (rst_n),
	.rst_n_sync  (shell_rst_n)
);

axil_softreg_bridge bridge_inst (
	.clk_main_a0 (clk_main_a0),
	.rst_n       (shell_rst_n),
	.awvalid, .awaddr, .awready,
	.wvalid, .wdata, .wstrb, .wready,
	.bvalid, .bresp, .bready,
	.arvalid, .araddr, .arready,
	.rvalid, .rdata, .rresp, .rready,
	.sr_req      (host_req),
	.sr_resp     (host_resp)
);

softreg_route_tree #(
	.NUM_APPS (`AOS_NUM_APPS)
) tree_inst (
	.clk_main_a0 (clk_main_a0),
	.rst_n       (shell_rst_n),
	.host_req    (host_req),
	.host_resp   (host_resp),
	.app_req     (app_req),
	.app_resp    (app_resp)
);

// --------------------
// App slots
// --------------------
for (genvar g = 0; g < `AOS_NUM_APPS; g++) begin : g_app
	// Own reset per slot region
	logic app_rst_n;

	rst_pipe app_rst_inst (
		.clk_main_a0 (clk_main_a0),
		.rst_n       (rst_n),
		.rst_n_sync  (app_rst_n)
	);

	app_regfile #(
		.APP_ID (g)
	) app_inst (
		.clk_main_a0 (clk_main_a0),
		.rst_n       (app_rst_n),
		.sr_req      (app_req[g]),
		.sr_resp     (app_resp[g])
	);
end

endmodule

`default_nettype wire

// File: logic/app_regfile.sv
// --------------------
// Slot register app
// Four scratch regs, a write counter and the slot id
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aos_config.svh"

module app_regfile #(
	parameter int APP_ID = 0
) (
	input  wire logic                  clk_main_a0,
	input  wire logic                  rst_n,
	input  wire aos_pkg::softreg_req_t sr_req,
	output aos_pkg::softreg_resp_t     sr_resp
);

// Register index sits right above the byte offset
localparam int BYTE_OFF_W  = `AOS_APP_SEL_LSB - `AOS_REG_IDX_W;
localparam int NUM_SCRATCH = 4;

logic [`AOS_REG_IDX_W-1:0]  reg_idx;
logic                       wr_en;
logic                       rd_en;
logic [`AOS_SR_DATA_W-1:0]  scratch_q [NUM_SCRATCH];
logic [`AOS_SR_DATA_W-1:0]  wr_count_q;
logic [`AOS_SR_DATA_W-1:0]  rd_data;
logic                       resp_valid_q;
logic [`AOS_SR_DATA_W-1:0]  resp_data_q;

assign reg_idx = sr_req.addr.raw[BYTE_OFF_W +: `AOS_REG_IDX_W];
assign wr_en   = sr_req.valid && !sr_req.is_read;
assign rd_en   = sr_req.valid && sr_req.is_read;

// --------------------
// Writes
// --------------------
always_ff @(posedge clk_main_a0 or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < NUM_SCRATCH; i++) begin
			scratch_q[i] <= '0;
		end
		wr_count_q <= '0;
	end else if (wr_en) begin
		// Every write counts, mapped or not
		wr_count_q <= wr_count_q + 1'b1;
		case (reg_idx)
			`AOS_REG_SCRATCH0: scratch_q[0] <= sr_req.data;
			`AOS_REG_SCRATCH1: scratch_q[1] <= sr_req.data;
			`AOS_REG_SCRATCH2: scratch_q[2] <= sr_req.data;
			`AOS_REG_SCRATCH3: scratch_q[3] <= sr_req.data;
			default: ;
		endcase
	end
end

// --------------------
// Reads
// --------------------
always_comb begin
	case (reg_idx)
		`AOS_REG_SCRATCH0: rd_data = scratch_q[0];
		`AOS_REG_SCRATCH1: rd_data = scratch_q[1];
		`AOS_REG_SCRATCH2: rd_data = scratch_q[2];
		`AOS_REG_SCRATCH3: rd_data = scratch_q[3];
		`AOS_REG_WR_COUNT: rd_data = wr_count_q;
		`AOS_REG_APP_ID:   rd_data = `AOS_SR_DATA_W'(APP_ID);
		// Unmapped reads as zero
		default:           rd_data = '0;
	endcase
end

always_ff @(posedge clk_main_a0 or negedge rst_n) begin
	if (!rst_n) begin
		resp_valid_q <= 1'b0;
	end else begin
		resp_valid_q <= rd_en;
	end
end

always_ff @(posedge clk_main_a0) begin
	if (rd_en) resp_data_q <= rd_data;
end

assign sr_resp = '{valid: resp_valid_q, data: resp_data_q};

a_resp_after_rd: assert property (@(posedge clk_main_a0) disable iff (!rst_n)
	sr_resp.valid |-> $past(sr_req.valid && sr_req.is_read));

endmodule

`default_nettype wire

// File: logic/axil_softreg_bridge.sv
// --------------------
// AXI-Lite to SoftReg bridge
// One host access at a time, issued as a single request strobe
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aos_config.svh"

module axil_softreg_bridge (
	input  wire logic                            clk_main_a0,
	input  wire logic                            rst_n,
	// Write address
	input  wire logic                            awvalid,
	input  wire logic [`AOS_SR_ADDR_W-1:0]       awaddr,
	output logic                                 awready,
	// Write data, byte strobes not supported
	input  wire logic                            wvalid,
	input  wire logic [`AOS_AXIL_DATA_W-1:0]     wdata,
	input  wire logic [`AOS_AXIL_DATA_W/8-1:0]   wstrb,
	output logic                                 wready,
	// Write response
	output logic                                 bvalid,
	output logic [1:0]                           bresp,
	input  wire logic                            bready,
	// Read address
	input  wire logic                            arvalid,
	input  wire logic [`AOS_SR_ADDR_W-1:0]       araddr,
	output logic                                 arready,
	// Read data
	output logic                                 rvalid,
	output logic [`AOS_AXIL_DATA_W-1:0]          rdata,
	output logic [1:0]                           rresp,
	input  wire logic                            rready,
	// SoftReg side, no grant
	output aos_pkg::softreg_req_t                sr_req,
	input  wire aos_pkg::softreg_resp_t          sr_resp
);

// FSM encoding
localparam logic [1:0] S_IDLE    = 2'd0;
localparam logic [1:0] S_WR_RESP = 2'd1;
localparam logic [1:0] S_RD_WAIT = 2'd2;
localparam logic [1:0] S_RD_RESP = 2'd3;
// Zero extension of host write data
localparam int PAD_W = `AOS_SR_DATA_W - `AOS_AXIL_DATA_W;

logic [1:0]                   state_q;
logic [1:0]                   state_d;
logic                         idle;
logic                         wr_take;
logic                         rd_take;
logic                         req_valid_q;
logic                         req_is_read_q;
logic [`AOS_SR_ADDR_W-1:0]    req_addr_q;
logic [`AOS_SR_DATA_W-1:0]    req_data_q;
logic [`AOS_AXIL_DATA_W-1:0]  rdata_q;

// --------------------
// Host handshakes
// --------------------
assign idle = (state_q == S_IDLE);

// AW and W only together, never half a write
assign awready = idle && (awvalid == wvalid);
assign wready  = awready;
// Write wins over a read offered in the same cycle
assign arready = idle && !(awvalid && wvalid);

assign wr_take = idle && awvalid && wvalid;
assign rd_take = idle && arvalid && !(awvalid && wvalid);

// Next state
always_comb begin
	state_d = state_q;
	case (state_q)
		S_IDLE: begin
			if (wr_take) begin
				state_d = S_WR_RESP;
			end else if (rd_take) begin
				state_d = S_RD_WAIT;
			end
		end
		// B goes out with the request, writes get no SoftReg response
		S_WR_RESP: if (bready) state_d = S_IDLE;
		// First valid response is ours
		S_RD_WAIT: if (sr_resp.valid) state_d = S_RD_RESP;
		S_RD_RESP: if (rready) state_d = S_IDLE;
		default:   state_d = S_IDLE;
	endcase
end

always_ff @(posedge clk_main_a0 or negedge rst_n) begin
	if (!rst_n) begin
		state_q     <= S_IDLE;
		req_valid_q <= 1'b0;
	end else begin
		state_q     <= state_d;
		// One-cycle strobe per accepted access
		req_valid_q <= wr_take || rd_take;
	end
end

// Request payload
always_ff @(posedge clk_main_a0) begin
	if (wr_take) begin
		req_is_read_q <= 1'b0;
		req_addr_q    <= awaddr;
		req_data_q    <= {{PAD_W{1'b0}}, wdata};
	end else if (rd_take) begin
		req_is_read_q <= 1'b1;
		req_addr_q    <= araddr;
		req_data_q    <= '0;
	end
end

// Read data, low word only
always_ff @(posedge clk_main_a0) begin
	if ((state_q == S_RD_WAIT) && sr_resp.valid) begin
		rdata_q <= sr_resp.data[`AOS_AXIL_DATA_W-1:0];
	end
end

// --------------------
// Outputs
// --------------------
always_comb begin
	sr_req.valid    = req_valid_q;
	sr_req.is_read  = req_is_read_q;
	sr_req.addr.raw = req_addr_q;
	sr_req.data     = req_data_q;
end

assign bvalid = (state_q == S_WR_RESP);
assign rvalid = (state_q == S_RD_RESP);
assign rdata  = rdata_q;
// Always OKAY
assign bresp  = 2'b00;
assign rresp  = 2'b00;

// Each host access is exactly one request beat
a_req_single: assert property (@(posedge clk_main_a0) disable iff (!rst_n)
	sr_req.valid |=> !sr_req.valid);

a_resp_excl: assert property (@(posedge clk_main_a0) disable iff (!rst_n)
	!(bvalid && rvalid));

endmodule

`default_nettype wire

// File: logic/rst_pipe.sv
// --------------------
// Reset pipe
// Asserts at once, releases after a few clean clock edges
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aos_config.svh"

module rst_pipe (
	input  wire logic clk_main_a0,
	input  wire logic rst_n,
	output logic      rst_n_sync
);

// Shift chain, stage 0 takes the constant one
logic [`AOS_RST_STAGES-1:0] sync_q;

// Clear asynchronously, fill with ones on the clock
always_ff @(posedge clk_main_a0 or negedge rst_n) begin
	if (!rst_n) begin
		sync_q <= '0;
	end else begin
		sync_q <= {sync_q[`AOS_RST_STAGES-2:0], 1'b1};
	end
end

// Release point for this region
assign rst_n_sync = sync_q[`AOS_RST_STAGES-1];

endmodule

`default_nettype wire

// File: logic/softreg_route_tree.sv
// --------------------
// SoftReg route tree
// Steers requests to one slot, merges slot responses back
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aos_config.svh"

module softreg_route_tree #(
	parameter int NUM_APPS = `AOS_NUM_APPS
) (
	input  wire logic                   clk_main_a0,
	input  wire logic                   rst_n,
	// Host side
	input  wire aos_pkg::softreg_req_t  host_req,
	output aos_pkg::softreg_resp_t      host_resp,
	// Slot side
	output aos_pkg::softreg_req_t       app_req  [NUM_APPS],
	input  wire aos_pkg::softreg_resp_t app_resp [NUM_APPS]
);

logic [`AOS_APP_SEL_W-1:0]  app_sel;
logic [NUM_APPS-1:0]        hit;
logic [NUM_APPS-1:0]        req_valid_q;
logic                       req_is_read_q;
aos_pkg::softreg_addr_u     req_addr_q;
logic [`AOS_SR_DATA_W-1:0]  req_data_q;
logic [NUM_APPS-1:0]        resp_valid;
logic [`AOS_SR_DATA_W-1:0]  resp_data_or;
logic                       resp_valid_q;
logic [`AOS_SR_DATA_W-1:0]  resp_data_q;

// --------------------
// Request path
// --------------------

// Slot index from the decoded view, upper bits alias
assign app_sel = host_req.addr.fields.app_sel;

always_comb begin
	for (int i = 0; i < NUM_APPS; i++) begin
		hit[i] = host_req.valid && (app_sel == `AOS_APP_SEL_W'(i));
	end
end

// Valid per slot
always_ff @(posedge clk_main_a0 or negedge rst_n) begin
	if (!rst_n) begin
		req_valid_q <= '0;
	end else begin
		req_valid_q <= hit;
	end
end

// Payload shared by all slots, only the selected one sees valid
always_ff @(posedge clk_main_a0) begin
	if (host_req.valid) begin
		req_is_read_q <= host_req.is_read;
		req_addr_q    <= host_req.addr;
		req_data_q    <= host_req.data;
	end
end

for (genvar g = 0; g < NUM_APPS; g++) begin : g_app
	assign app_req[g] = '{valid: req_valid_q[g], is_read: req_is_read_q,
		addr: req_addr_q, data: req_data_q};
end

// --------------------
// Response path
// --------------------

// OR merge, idle slots masked off
always_comb begin
	resp_data_or = '0;
	for (int i = 0; i < NUM_APPS; i++) begin
		resp_valid[i] = app_resp[i].valid;
		if (app_resp[i].valid) begin
			resp_data_or = resp_data_or | app_resp[i].data;
		end
	end
end

always_ff @(posedge clk_main_a0 or negedge rst_n) begin
	if (!rst_n) begin
		resp_valid_q <= 1'b0;
	end else begin
		resp_valid_q <= |resp_valid;
	end
end

always_ff @(posedge clk_main_a0) begin
	if (|resp_valid) begin
		resp_data_q <= resp_data_or;
	end
end

assign host_resp = '{valid: resp_valid_q, data: resp_data_q};

// Merge is lossless only if slots never answer together
a_one_resp: assert property (@(posedge clk_main_a0) disable iff (!rst_n)
	$onehot0(resp_valid));

endmodule

`default_nettype wire

// File: verification/aos_shell_tb.sv
// --------------------
// Shell testbench
// Directed AXI-Lite tests of the SoftReg slot registers
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "aos_config.svh"

module aos_shell_tb;

localparam int CLK_PERIOD = 8;
localparam int SEED       = 91635;
localparam int NUM_APPS   = `AOS_NUM_APPS;
// Register index sits above the byte offset
localparam int REG_LSB    = `AOS_APP_SEL_LSB - `AOS_REG_IDX_W;
// Host transactions over all tests, 32 + 4 + 26 + 20 + 8
localparam int NUM_TXNS   = 90;
localparam int WATCHDOG_CYCLES = NUM_TXNS * 200;

logic                          clk_main_a0;
logic                          rst_n;
logic                          awvalid;
logic [`AOS_SR_ADDR_W-1:0]     awaddr;
logic                          awready;
logic                          wvalid;
logic [`AOS_AXIL_DATA_W-1:0]   wdata;
logic [`AOS_AXIL_DATA_W/8-1:0] wstrb;
logic                          wready;
logic                          bvalid;
logic [1:0]                    bresp;
logic                          bready;
logic                          arvalid;
logic [`AOS_SR_ADDR_W-1:0]     araddr;
logic                          arready;
logic                          rvalid;
logic [`AOS_AXIL_DATA_W-1:0]   rdata;
logic [1:0]                    rresp;
logic                          rready;

// Expected register contents per slot
logic [31:0] exp_scratch [NUM_APPS][4];
int          exp_count   [NUM_APPS];
string       test_name;
int          errors;
int          tests_run;
int          tests_failed;
int          test_start_errors;
logic [31:0] seed_val;

aos_shell aos_shell_inst (
	.clk_main_a0 (clk_main_a0),
	.rst_n       (rst_n),
	.awvalid     (awvalid),
	.awaddr      (awaddr),
	.awready     (awready),
	.wvalid      (wvalid),
	.wdata       (wdata),
	.wstrb       (wstrb),
	.wready      (wready),
	.bvalid      (bvalid),
	.bresp       (bresp),
	.bready      (bready),
	.arvalid     (arvalid),
	.araddr      (araddr),
	.arready     (arready),
	.rvalid      (rvalid),
	.rdata       (rdata),
	.rresp       (rresp),
	.rready      (rready)
);

always #(CLK_PERIOD / 2) clk_main_a0 = ~clk_main_a0;

// --------------------
// Helpers
// --------------------
task automatic check(input string what, input logic [63:0] expected, input logic [63:0] actual);
	if (expected !== actual) begin
		$display("MISMATCH %s %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
		errors++;
	end
endtask

task automatic flag_error(input string msg);
	$display("ERROR in %s: %s", test_name, msg);
	errors++;
endtask

function automatic logic [31:0] addr_of(input int slot, input int idx);
	return (slot << `AOS_APP_SEL_LSB) | (idx << REG_LSB);
endfunction

// Slot from bits 9:8, register from bits 7:3, high bits ignored
task automatic record_write(input logic [31:0] addr, input logic [31:0] data);
	int slot;
	int idx;
	slot = addr[`AOS_APP_SEL_LSB +: `AOS_APP_SEL_W];
	idx  = addr[REG_LSB +: `AOS_REG_IDX_W];
	exp_count[slot]++;
	if (idx < 4) exp_scratch[slot][idx] = data;
endtask

task automatic axil_write(input logic [31:0] addr, input logic [31:0] data, input int hold);
	int i;
	@(posedge clk_main_a0);
	#1;
	awvalid = 1'b1;
	awaddr  = addr;
	wvalid  = 1'b1;
	wdata   = data;
	@(negedge clk_main_a0);
	while (!(awready && wready)) @(negedge clk_main_a0);
	@(posedge clk_main_a0);
	#1;
	awvalid = 1'b0;
	wvalid  = 1'b0;
	@(negedge clk_main_a0);
	while (!bvalid) @(negedge clk_main_a0);
	check("bresp", 64'd0, bresp);
	// B held off by the host
	for (i = 0; i < hold; i++) begin
		if (!bvalid) flag_error("bvalid dropped while bready was low");
		if (awready || arready) flag_error("new address accepted while B was pending");
		@(negedge clk_main_a0);
	end
	if (!bvalid) flag_error("bvalid dropped before the handshake");
	@(posedge clk_main_a0);
	#1;
	bready = 1'b1;
	@(posedge clk_main_a0);
	#1;
	bready = 1'b0;
	record_write(addr, data);
endtask

task automatic axil_read(input logic [31:0] addr, input int hold, output logic [31:0] data);
	int i;
	@(posedge clk_main_a0);
	#1;
	arvalid = 1'b1;
	araddr  = addr;
	@(negedge clk_main_a0);
	while (!arready) @(negedge clk_main_a0);
	@(posedge clk_main_a0);
	#1;
	arvalid = 1'b0;
	@(negedge clk_main_a0);
	while (!rvalid) @(negedge clk_main_a0);
	data = rdata;
	check("rresp", 64'd0, rresp);
	// R held off, data must not move
	for (i = 0; i < hold; i++) begin
		if (!rvalid) flag_error("rvalid dropped while rready was low");
		if (rdata !== data) flag_error("rdata changed while rready was low");
		if (awready || arready) flag_error("new address accepted while R was pending");
		@(negedge clk_main_a0);
	end
	if (!rvalid) flag_error("rvalid dropped before the handshake");
	@(posedge clk_main_a0);
	#1;
	rready = 1'b1;
	@(posedge clk_main_a0);
	#1;
	rready = 1'b0;
endtask

task automatic begin_test(input string name);
	test_name         = name;
	test_start_errors = errors;
	tests_run++;
endtask

task automatic end_test();
	if (errors == test_start_errors) begin
		$display("test %s: pass", test_name);
	end else begin
		$display("test %s: %0d errors", test_name, errors - test_start_errors);
		tests_failed++;
	end
endtask

// --------------------
// Tests
// --------------------
task automatic test_reset_state();
	begin_test("reset_state");
	@(negedge clk_main_a0);
	if (bvalid) flag_error("bvalid is high after reset");
	if (rvalid) flag_error("rvalid is high after reset");
	if (!awready) flag_error("awready is low after reset");
	if (!wready) flag_error("wready is low after reset");
	if (!arready) flag_error("arready is low after reset");
	end_test();
endtask

task automatic test_scratch();
	logic [31:0] rd;
	begin_test("scratch");
	for (int s = 0; s < NUM_APPS; s++) begin
		for (int r = 0; r < 4; r++) begin
			axil_write(addr_of(s, `AOS_REG_SCRATCH0 + r), $urandom, 0);
		end
	end
	// Read back only after every slot was written
	for (int s = 0; s < NUM_APPS; s++) begin
		for (int r = 0; r < 4; r++) begin
			axil_read(addr_of(s, `AOS_REG_SCRATCH0 + r), 0, rd);
			check("scratch", exp_scratch[s][r], rd);
		end
	end
	end_test();
endtask

task automatic test_app_id();
	logic [31:0] rd;
	begin_test("app_id");
	for (int s = 0; s < NUM_APPS; s++) begin
		axil_read(addr_of(s, `AOS_REG_APP_ID), 0, rd);
		check("app id", s, rd);
	end
	end_test();
endtask

task automatic test_wr_count();
	logic [31:0] rd;
	begin_test("wr_count");
	for (int s = 0; s < NUM_APPS; s++) begin
		// Slot s gets s+1 writes to an unmapped index
		for (int n = 0; n <= s; n++) begin
			axil_write(addr_of(s, 5), $urandom, 0);
		end
		for (int j = 0; j < NUM_APPS; j++) begin
			axil_read(addr_of(j, `AOS_REG_WR_COUNT), 0, rd);
			check("write count", exp_count[j], rd);
		end
	end
	end_test();
endtask

task automatic test_unmapped_alias();
	logic [31:0] rd;
	logic [31:0] hi;
	logic [31:0] alias_mask;
	begin_test("unmapped_alias");
	for (int s = 0; s < NUM_APPS; s++) begin
		axil_read(addr_of(s, 4), 0, rd);
		check("index 4", 0, rd);
		axil_read(addr_of(s, 5), 0, rd);
		check("index 5", 0, rd);
		// Bits above the slot index, top bit forced so the alias differs
		hi         = $urandom;
		alias_mask = {1'b1, hi[30:10], 10'd0};
		axil_write(alias_mask | addr_of(s, `AOS_REG_SCRATCH2), $urandom, 0);
		axil_read(addr_of(s, `AOS_REG_SCRATCH2), 0, rd);
		check("alias write", exp_scratch[s][2], rd);
		axil_read(alias_mask | addr_of(s, `AOS_REG_SCRATCH1), 0, rd);
		check("alias read", exp_scratch[s][1], rd);
	end
	end_test();
endtask

task automatic test_backpressure();
	logic [31:0] rd;
	begin_test("backpressure");
	for (int s = 0; s < NUM_APPS; s++) begin
		axil_write(addr_of(s, `AOS_REG_SCRATCH3), $urandom, $urandom_range(12, 1));
	end
	for (int s = 0; s < NUM_APPS; s++) begin
		axil_read(addr_of(s, `AOS_REG_SCRATCH3), $urandom_range(12, 1), rd);
		check("held read", exp_scratch[s][3], rd);
	end
	end_test();
endtask

// --------------------
// Run
// --------------------
initial begin
	seed_val    = $urandom(SEED);
	clk_main_a0 = 1'b0;
	rst_n       = 1'b0;
	awvalid     = 1'b0;
	awaddr      = '0;
	wvalid      = 1'b0;
	wdata       = '0;
	wstrb       = '1;
	bready      = 1'b0;
	arvalid     = 1'b0;
	araddr      = '0;
	rready      = 1'b0;
	errors       = 0;
	tests_run    = 0;
	tests_failed = 0;
	for (int s = 0; s < NUM_APPS; s++) begin
		exp_count[s] = 0;
		for (int r = 0; r < 4; r++) begin
			exp_scratch[s][r] = '0;
		end
	end
	repeat (5) @(posedge clk_main_a0);
	#1;
	rst_n = 1'b1;
	// Reset pipes release a few edges later
	repeat (`AOS_RST_STAGES + 2) @(posedge clk_main_a0);
	test_reset_state();
	test_scratch();
	test_app_id();
	test_wr_count();
	test_unmapped_alias();
	test_backpressure();
	$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
	if (errors == 0) begin
		$display("TESTS PASSED");
	end else begin
		$display("TESTS FAILED");
	end
	$finish;
end

// Hang guard
initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk_main_a0);
	$display("ERROR: watchdog expired after %0d cycles, the DUT stopped responding",
		WATCHDOG_CYCLES);
	$display("TESTS FAILED");
	$finish;
end

endmodule

`default_nettype wire
